// ==== store_subsys.f ====
rtl/sq_pkg.sv
rtl/store_addr_gen.sv
rtl/store_queue.sv
rtl/store_mem_port.sv
rtl/data_mem.sv
rtl/store_subsys.sv
tb/store_subsys_asserts.sv
tb/store_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the store subsystem testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module store_subsys_tb -f store_subsys.f -o sim_store_subsys
./obj_dir/sim_store_subsys | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb/store_subsys_tb.sv ====
`timescale 1ns/1ps

module store_subsys_tb
    import sq_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int STORE_CYCLES = MEM_LATENCY + 2;
    // Stores issued over all tests
    localparam int N_STORES     = 22;
    // Each store gets its completion latency three times over, plus slack for resets
    localparam int WATCHDOG_CYCLES = N_STORES * STORE_CYCLES * 3 + 200;

    // Expected completion, kept in queue order
    typedef struct packed {
        rob_tag_t  tag;
        addr_t     addr;
        mem_size_t size;
        data_t     data;
    } exp_store_t;

    logic       clock;
    logic       reset;
    credit_t    num_store_dispatched;
    credit_t    open_entries;
    logic       issue_valid;
    sq_issue_t  issue_pkt;
    logic       start_store;
    logic       br_en;
    sq_idx_t    br_tail;
    sq_idx_t    sq_head;
    sq_idx_t    sq_tail;
    logic       store_busy;
    logic       done_valid;
    sq_done_t   done_pkt;
    addr_t      ld_addr;
    data_t      ld_data;

    logic [31:0] lfsr;
    data_t       model [MEM_WORDS];
    exp_store_t  expected [$];

    store_subsys DUT (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Galois LFSR, one step per data bit
    function automatic data_t next_rand();
        data_t word;
        logic  bit_out;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            bit_out = lfsr[0];
            lfsr    = (lfsr >> 1) ^ (bit_out ? 32'h8020_0003 : 32'h0);
            word    = {word[30:0], bit_out};
        end
        return word;
    endfunction

    // Base plus signed 12-bit offset
    function automatic addr_t eff_addr(input addr_t base, input logic [11:0] imm);
        int offset;
        offset = $signed(imm);
        return base + addr_t'(offset);
    endfunction

    // Only the addressed lanes take the low bytes of the data
    function automatic void update_model(input exp_store_t s);
        int w;
        int o;
        w = (s.addr >> 2) % MEM_WORDS;
        o = s.addr[1:0];
        case (s.size)
            MEM_BYTE: model[w][8*o +: 8]  = s.data[7:0];
            MEM_HALF: model[w][8*o +: 16] = s.data[15:0];
            default:  model[w]            = s.data;
        endcase
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b0;
    endtask

    // All stimulus tasks start and end right after a falling edge
    task automatic dispatch(input int n);
        if (open_entries < credit_t'(n)) begin
            fail_now("dispatch would exceed the credit from the store queue");
        end
        num_store_dispatched = credit_t'(n);
        @(negedge clock);
        num_store_dispatched = '0;
    endtask

    task automatic issue(input sq_idx_t idx, input rob_tag_t tag, input addr_t base,
                         input logic [11:0] imm, input data_t data, input mem_size_t size);
        issue_valid = 1'b1;
        issue_pkt   = '{sq_idx: idx, rob_tag: tag, base: base, imm: imm,
                        store_data: data, size: size};
        expected.push_back('{tag: tag, addr: eff_addr(base, imm), size: size, data: data});
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    task automatic check_done();
        exp_store_t s;
        s = expected.pop_front();
        check("done_pkt.rob_tag", done_pkt.rob_tag, s.tag);
        check("done_pkt.addr", done_pkt.addr, s.addr);
        update_model(s);
    endtask

    // One retire request, then wait for its completion
    task automatic retire_one();
        sq_idx_t head_before;
        int      waited;
        head_before = sq_head;
        start_store = 1'b1;
        @(negedge clock);
        start_store = 1'b0;
        check("sq_head", sq_head, sq_idx_t'(head_before + 1));
        // Write request cycle, memory is now busy
        check("store_busy", store_busy, 1);
        waited = 1;
        while (!done_valid && waited <= 2 * STORE_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        if (!done_valid) begin
            fail_now("no completion arrived after a retired store");
        end
        check("done_valid latency", waited, STORE_CYCLES);
        // Busy window closed one cycle before the completion
        check("store_busy", store_busy, 0);
        check_done();
    endtask

    // Load data shows up one cycle after the address
    task automatic readback(input addr_t addr);
        ld_addr = addr;
        @(negedge clock);
        check("ld_data", ld_data, model[(addr >> 2) % MEM_WORDS]);
    endtask

    task automatic store_and_check(input rob_tag_t tag, input addr_t base,
                                   input logic [11:0] imm, input data_t data,
                                   input mem_size_t size);
        sq_idx_t idx;
        idx = sq_tail;
        dispatch(1);
        issue(idx, tag, base, imm, data, size);
        retire_one();
        readback(eff_addr(base, imm));
    endtask

    task automatic test_credits();
        apply_reset();
        check("open_entries", open_entries, DISPATCH_WIDTH);
        repeat (SQ_DEPTH / DISPATCH_WIDTH) dispatch(DISPATCH_WIDTH);
        check("open_entries", open_entries, 0);
        check("sq_tail", sq_tail, 0);
        issue(3'd0, 5'd1, 32'h40, 12'h000, next_rand(), MEM_WORD);
        retire_one();
        check("open_entries", open_entries, 1);
        readback(32'h40);
    endtask

    task automatic test_word_stores();
        apply_reset();
        // Odd stores use a negative offset
        for (int i = 0; i < 4; i++) begin
            store_and_check(rob_tag_t'(8 + i), 32'h80 + 16 * i,
                            (i % 2) ? 12'hffc : 12'h008, next_rand(), MEM_WORD);
        end
    endtask

    task automatic test_byte_half();
        apply_reset();
        store_and_check(5'd16, 32'h20, 12'h000, 32'ha5a5_5a5a, MEM_WORD);
        store_and_check(5'd17, 32'h20, 12'h001, next_rand(), MEM_BYTE);
        store_and_check(5'd18, 32'h20, 12'h003, next_rand(), MEM_BYTE);
        store_and_check(5'd19, 32'h1e, 12'h004, next_rand(), MEM_HALF);
        store_and_check(5'd20, 32'h24, 12'hffc, next_rand(), MEM_HALF);
    endtask

    task automatic test_squash();
        addr_t   a [4];
        sq_idx_t first;
        apply_reset();
        // Known words at every target first
        for (int i = 0; i < 4; i++) begin
            a[i] = 32'hc0 + 4 * i;
            store_and_check(rob_tag_t'(24 + i), a[i], 12'h000, 32'h1111_1111 * (i + 1), MEM_WORD);
        end
        // Four new stores from slot 4, tail wraps to 0
        first = sq_tail;
        dispatch(2);
        dispatch(2);
        for (int i = 0; i < 4; i++) begin
            issue(sq_idx_t'(first + i), rob_tag_t'(28 + i), a[i], 12'h000, next_rand(), MEM_WORD);
        end
        // Tail rolls back to just past the second store
        br_en   = 1'b1;
        br_tail = sq_idx_t'(first + 2);
        @(negedge clock);
        br_en   = 1'b0;
        void'(expected.pop_back());
        void'(expected.pop_back());
        check("open_entries", open_entries, DISPATCH_WIDTH);
        check("sq_tail", sq_tail, sq_idx_t'(first + 2));
        retire_one();
        retire_one();
        // Head now sits on a cleared slot
        start_store = 1'b1;
        repeat (2 * STORE_CYCLES) begin
            @(negedge clock);
            if (done_valid) begin
                fail_now("a squashed store reached memory");
            end
        end
        start_store = 1'b0;
        check("sq_head", sq_head, sq_idx_t'(first + 2));
        for (int i = 0; i < 4; i++) readback(a[i]);
    endtask

    task automatic test_back_pressure();
        int      cyc;
        int      n_done;
        int      req_cyc [$];
        sq_idx_t last_head;
        apply_reset();
        dispatch(2);
        dispatch(2);
        for (int i = 0; i < 4; i++) begin
            issue(sq_idx_t'(i), rob_tag_t'(2 + i), 32'h60 + 4 * i, 12'h000, next_rand(), MEM_WORD);
        end
        // Request held high, memory decides when each store goes
        start_store = 1'b1;
        last_head   = sq_head;
        cyc         = 0;
        n_done      = 0;
        while (n_done < 4) begin
            @(negedge clock);
            cyc++;
            if (cyc > 8 * STORE_CYCLES) begin
                fail_now("stores stalled while start_store was held high");
            end
            // Head moved, so the request in the previous cycle was taken
            if (sq_head != last_head) begin
                req_cyc.push_back(cyc - 1);
                last_head = sq_head;
            end
            if (done_valid) begin
                if (req_cyc.size() == 0) begin
                    fail_now("completion arrived without an accepted store");
                end
                check("done_valid latency", cyc - req_cyc.pop_front(), STORE_CYCLES);
                check_done();
                n_done++;
            end
        end
        repeat (2 * STORE_CYCLES) begin
            @(negedge clock);
            if (done_valid) begin
                fail_now("extra completion after the queue drained");
            end
        end
        start_store = 1'b0;
        check("sq_head", sq_head, 4);
        check("open_entries", open_entries, DISPATCH_WIDTH);
        for (int i = 0; i < 4; i++) readback(32'h60 + 4 * i);
    endtask

    initial begin
        clock                = 1'b0;
        reset                = 1'b1;
        num_store_dispatched = '0;
        issue_valid          = 1'b0;
        issue_pkt            = '0;
        start_store          = 1'b0;
        br_en                = 1'b0;
        br_tail              = '0;
        ld_addr              = '0;
        lfsr                 = 32'hdf42;
        test_credits();
        test_word_stores();
        test_byte_half();
        test_squash();
        test_back_pressure();
        $display("TB PASSED");
        $finish;
    end

    // Hard stop if some wait never ends
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("TB FAILED");
        $fatal(1);
    end

endmodule

// ==== tb/store_subsys_asserts.sv ====
`timescale 1ns/1ps

module store_subsys_asserts
    import sq_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      exec_valid,
    input logic      store_busy,
    input sq_count_t count,
    input logic      pulse
);

    // Memory port takes a store only while idle, then stays busy with it
    a_exec_idle: assert property (@(posedge clock) disable iff (reset)
        exec_valid |-> !store_busy ##1 store_busy)
        else $error("exec_valid high while store_busy is high");

    a_count_max: assert property (@(posedge clock) disable iff (reset)
        count <= sq_count_t'(SQ_DEPTH))
        else $error("occupancy above SQ_DEPTH");

    // Request lasts exactly one cycle
    a_single_pulse: assert property (@(posedge clock) disable iff (reset)
        pulse |=> !pulse)
        else $error("request held longer than one cycle");

endmodule

bind store_queue store_subsys_asserts u_queue_asserts (
    .clock      (clock),
    .reset      (reset),
    .exec_valid (exec_valid),
    .store_busy (store_busy),
    .count      (sq_count),
    .pulse      (exec_valid)
);

// Port occupancy is the single store in flight
bind store_mem_port store_subsys_asserts u_port_asserts (
    .clock      (clock),
    .reset      (reset),
    .exec_valid (exec_valid),
    .store_busy (store_busy),
    .count      ({3'b000, busy_q}),
    .pulse      (wr_en)
);

// ==== rtl/store_subsys.sv ====
`timescale 1ns/1ps

module store_subsys
    import sq_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  credit_t   num_store_dispatched,
    output credit_t   open_entries,

    input  logic      issue_valid,
    input  sq_issue_t issue_pkt,

    input  logic      start_store,
    input  logic      br_en,
    input  sq_idx_t   br_tail,

    output sq_idx_t   sq_head,
    output sq_idx_t   sq_tail,
    output logic      store_busy,

    output logic      done_valid,
    output sq_done_t  done_pkt,

    input  addr_t     ld_addr,
    output data_t     ld_data
);

    sq_entry_t  issue_entry;
    logic       exec_valid;
    sq_entry_t  exec_entry;
    logic       wr_en;
    addr_t      wr_addr;
    byte_mask_t wr_mask;
    data_t      wr_data;
    logic       wr_done;

    // Address, mask and lane shift for the issuing store
    store_addr_gen u_addr_gen (
        .issue_pkt (issue_pkt),
        .entry     (issue_entry)
    );

    store_queue u_queue (
        .clock                (clock),
        .reset                (reset),
        .num_store_dispatched (num_store_dispatched),
        .issue_valid          (issue_valid),
        .issue_entry          (issue_entry),
        .issue_idx            (issue_pkt.sq_idx),
        .start_store          (start_store),
        .store_busy           (store_busy),
        .br_en                (br_en),
        .br_tail              (br_tail),
        .open_entries         (open_entries),
        .sq_head              (sq_head),
        .sq_tail              (sq_tail),
        .exec_valid           (exec_valid),
        .exec_entry           (exec_entry)
    );

    // One store in flight between queue and RAM
    store_mem_port u_mem_port (
        .clock      (clock),
        .reset      (reset),
        .exec_valid (exec_valid),
        .exec_entry (exec_entry),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_mask    (wr_mask),
        .wr_data    (wr_data),
        .wr_done    (wr_done),
        .store_busy (store_busy),
        .done_valid (done_valid),
        .done_pkt   (done_pkt)
    );

    data_mem u_data_mem (
        .clock   (clock),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_mask (wr_mask),
        .wr_data (wr_data),
        .wr_done (wr_done),
        .ld_addr (ld_addr),
        .ld_data (ld_data)
    );

endmodule

// ==== rtl/data_mem.sv ====
`timescale 1ns/1ps

module data_mem
    import sq_pkg::*;
(
    input  logic       clock,
    input  logic       reset,

    input  logic       wr_en,
    input  addr_t      wr_addr,
    input  byte_mask_t wr_mask,
    input  data_t      wr_data,
    output logic       wr_done,

    input  addr_t      ld_addr,
    output data_t      ld_data
);

    data_t                            mem [MEM_WORDS];
    logic                             active;
    logic [$clog2(MEM_LATENCY+1)-1:0] lat_cnt;
    logic [$clog2(MEM_WORDS)-1:0]     pend_idx;
    logic [$clog2(MEM_WORDS)-1:0]     ld_idx;
    byte_mask_t                       pend_mask;
    data_t                            pend_data;

    // Word index from the byte address
    assign ld_idx  = ld_addr[$clog2(MEM_WORDS)+1:2];
    assign wr_done = active && (lat_cnt == '0);

    // Latency counter, expires MEM_LATENCY cycles after wr_en
    always_ff @(posedge clock) begin
        if (reset) begin
            active  <= 1'b0;
            lat_cnt <= '0;
        end else if (wr_en) begin
            active  <= 1'b1;
            lat_cnt <= ($clog2(MEM_LATENCY+1))'(MEM_LATENCY - 1);
        end else if (wr_done) begin
            active  <= 1'b0;
        end else if (active) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            pend_idx  <= wr_addr[$clog2(MEM_WORDS)+1:2];
            pend_mask <= wr_mask;
            pend_data <= wr_data;
        end
        // Byte-enabled update on the completion edge
        if (wr_done) begin
            for (int b = 0; b < 4; b++) begin
                if (pend_mask[b]) begin
                    mem[pend_idx][8*b +: 8] <= pend_data[8*b +: 8];
                end
            end
        end
        // Registered load read
        ld_data <= mem[ld_idx];
    end

endmodule

// ==== rtl/store_mem_port.sv ====
`timescale 1ns/1ps

module store_mem_port
    import sq_pkg::*;
(
    input  logic       clock,
    input  logic       reset,

    input  logic       exec_valid,
    input  sq_entry_t  exec_entry,

    output logic       wr_en,
    output addr_t      wr_addr,
    output byte_mask_t wr_mask,
    output data_t      wr_data,
    input  logic       wr_done,

    output logic       store_busy,
    output logic       done_valid,
    output sq_done_t   done_pkt
);

    logic       busy_q;
    rob_tag_t   pend_tag;
    logic [1:0] low_offset;

    // Drops in the wr_done cycle so the next store can be accepted there
    assign store_busy = busy_q && !wr_done;

    // Lowest enabled lane recovers the byte offset of the store
    always_comb begin
        if (wr_mask[0]) begin
            low_offset = 2'd0;
        end else if (wr_mask[1]) begin
            low_offset = 2'd1;
        end else if (wr_mask[2]) begin
            low_offset = 2'd2;
        end else begin
            low_offset = 2'd3;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q     <= 1'b0;
            wr_en      <= 1'b0;
            done_valid <= 1'b0;
        end else begin
            // Single-cycle write request
            wr_en      <= exec_valid;
            done_valid <= wr_done;
            // New store wins over a completion in the same cycle
            if (exec_valid) begin
                busy_q <= 1'b1;
            end else if (wr_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (exec_valid) begin
            pend_tag <= exec_entry.rob_tag;
            wr_addr  <= exec_entry.word_addr;
            wr_mask  <= exec_entry.mask;
            wr_data  <= exec_entry.data;
        end
        // Old pend_tag is sampled even if a new store lands this edge
        if (wr_done) begin
            done_pkt.rob_tag <= pend_tag;
            done_pkt.addr    <= {wr_addr[31:2], low_offset};
        end
    end

endmodule

// ==== rtl/store_queue.sv ====
`timescale 1ns/1ps

module store_queue
    import sq_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // Dispatch allocates this many slots at the tail
    input  credit_t   num_store_dispatched,

    // Issue fills the slot saved at dispatch
    input  logic      issue_valid,
    input  sq_entry_t issue_entry,
    input  sq_idx_t   issue_idx,

    // Retire request from the ROB and back-pressure from memory
    input  logic      start_store,
    input  logic      store_busy,

    // Branch squash rolls the tail back
    input  logic      br_en,
    input  sq_idx_t   br_tail,

    output credit_t   open_entries,
    output sq_idx_t   sq_head,
    output sq_idx_t   sq_tail,

    output logic      exec_valid,
    output sq_entry_t exec_entry
);

    sq_entry_t entries      [SQ_DEPTH];
    sq_entry_t next_entries [SQ_DEPTH];

    sq_idx_t   head;
    sq_idx_t   next_head;
    // Tail points one past the youngest allocated slot
    sq_idx_t   tail;
    sq_idx_t   next_tail;
    sq_count_t sq_count;
    sq_count_t next_count;

    sq_count_t free_slots;
    sq_idx_t   squash_cnt;
    logic      execute;

    // Head goes to memory only once issued and the port is idle
    assign execute = start_store && entries[head].valid && entries[head].issued
                     && !store_busy;

    // Head being freed this cycle counts as a free slot
    assign free_slots   = sq_count_t'(SQ_DEPTH) - sq_count + sq_count_t'(execute);
    assign open_entries = (free_slots > sq_count_t'(DISPATCH_WIDTH)) ?
                          credit_t'(DISPATCH_WIDTH) : credit_t'(free_slots);

    // Slots between br_tail and tail, wraps naturally in 3 bits
    assign squash_cnt = br_en ? sq_idx_t'(tail - br_tail) : '0;

    assign exec_valid = execute;
    assign exec_entry = entries[head];
    assign sq_head    = head;
    assign sq_tail    = tail;

    always_comb begin
        sq_idx_t rel;
        sq_idx_t slot;

        next_entries = entries;

        // Issue writes address, mask and data into its slot
        if (issue_valid) begin
            next_entries[issue_idx] = issue_entry;
        end

        // Clear every slot from br_tail up to the old tail
        for (int i = 0; i < SQ_DEPTH; i++) begin
            rel = sq_idx_t'(i) - br_tail;
            if (rel < squash_cnt) begin
                next_entries[i] = '0;
            end
        end

        // Executing head leaves the queue
        if (execute) begin
            next_entries[head] = '0;
        end

        // New slots start from the rolled-back tail when squashing
        next_tail = br_en ? br_tail : tail;

        // Allocation last, a full queue may reuse the slot freed by retire
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            slot = next_tail + sq_idx_t'(k);
            if (credit_t'(k) < num_store_dispatched) begin
                next_entries[slot]       = '0;
                next_entries[slot].valid = 1'b1;
            end
        end

        next_tail  = next_tail + sq_idx_t'(num_store_dispatched);
        next_head  = execute ? head + 1'b1 : head;
        next_count = sq_count + sq_count_t'(num_store_dispatched)
                     - sq_count_t'(execute) - sq_count_t'(squash_cnt);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            sq_count <= '0;
            entries  <= '{default: '0};
        end else begin
            head     <= next_head;
            tail     <= next_tail;
            sq_count <= next_count;
            entries  <= next_entries;
        end
    end

endmodule

// ==== rtl/store_addr_gen.sv ====
`timescale 1ns/1ps

module store_addr_gen
    import sq_pkg::*;
(
    input  sq_issue_t issue_pkt,
    output sq_entry_t entry
);

    addr_t      byte_addr;
    byte_mask_t size_mask;
    byte_mask_t lane_mask;
    data_t      shifted;
    data_t      lane_data;

    always_comb begin
        // Base plus sign-extended 12-bit immediate
        byte_addr = issue_pkt.base + {{20{issue_pkt.imm[11]}}, issue_pkt.imm};

        // Lanes touched before the offset is applied
        case (issue_pkt.size)
            MEM_BYTE: size_mask = 4'b0001;
            MEM_HALF: size_mask = 4'b0011;
            default:  size_mask = 4'b1111;
        endcase

        // Stores are aligned, so the shift never pushes lanes out of the word
        lane_mask = size_mask << byte_addr[1:0];
        shifted   = issue_pkt.store_data << {byte_addr[1:0], 3'b000};

        // Zero the lanes the RAM will not write
        for (int b = 0; b < 4; b++) begin
            lane_data[8*b +: 8] = lane_mask[b] ? shifted[8*b +: 8] : 8'h00;
        end

        entry.valid     = 1'b1;
        entry.issued    = 1'b1;
        entry.rob_tag   = issue_pkt.rob_tag;
        entry.word_addr = {byte_addr[31:2], 2'b00};
        entry.mask      = lane_mask;
        entry.data      = lane_data;
    end

endmodule

// ==== rtl/sq_pkg.sv ====
package sq_pkg;

    // Queue and dispatch sizing
    localparam int SQ_DEPTH       = 8;
    localparam int DISPATCH_WIDTH = 2;

    // Data memory
    localparam int MEM_LATENCY = 3;
    localparam int MEM_WORDS   = 64;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [2:0]  sq_idx_t;
    // Occupancy 0..SQ_DEPTH needs one bit more than the index
    typedef logic [3:0]  sq_count_t;
    // Dispatch count and credit, 0..DISPATCH_WIDTH
    typedef logic [1:0]  credit_t;
    typedef logic [4:0]  rob_tag_t;
    typedef logic [3:0]  byte_mask_t;

    // Matches funct3[1:0] of SB, SH and SW
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    // Store as it leaves the reservation station
    typedef struct packed {
        sq_idx_t    sq_idx;      // Slot saved at dispatch
        rob_tag_t   rob_tag;
        data_t      base;        // rs1 value
        logic [11:0] imm;        // S-type immediate
        data_t      store_data;  // rs2 value
        mem_size_t  size;
    } sq_issue_t;

    // One store queue slot
    typedef struct packed {
        logic       valid;       // Allocated at dispatch
        logic       issued;      // Address and data known
        rob_tag_t   rob_tag;
        addr_t      word_addr;   // Byte address with low two bits cleared
        byte_mask_t mask;
        data_t      data;        // Already shifted into its byte lanes
    } sq_entry_t;

    // Completion for the common data bus
    typedef struct packed {
        rob_tag_t rob_tag;
        addr_t    addr;
    } sq_done_t;

endpackage
